/* include/mpf_params.svh */
/*
 * Build-time settings for the read-response sorting shim.
 * Included by the package and by any module that sizes hardware from them.
 */

`ifndef MPF_PARAMS_SVH
`define MPF_PARAMS_SVH

// Cache-line address and (reduced) data widths
`define MPF_ADDR_WIDTH 32
`define MPF_DATA_WIDTH 64

// User metadata field, which also carries the scoreboard tag toward the platform
`define MPF_MDATA_WIDTH 16

// The scoreboard depth must be a power of two
`define MPF_SB_ENTRIES 16

// Free slots kept back so requests in flight after almost-full still fit
`define MPF_ALMOST_FULL_RESERVE 4

// Set to 1 to merge the channel almost-full flags and keep load/store order
`define MPF_SYNC_REQ_CHANNELS 1

`endif

/* hdl/mpf_pkg.sv */
/*
 * Channel types shared by the sorting shim, its top level and the testbench.
 * Import with a wildcard in the module header; widths come from the params header.
 */

`include "mpf_params.svh"

package mpfPkg;

    // User metadata, replaced by the slot tag on the platform side
    typedef logic [`MPF_MDATA_WIDTH-1:0] tMdata;

    // Kind of response carried on channel 0
    typedef enum logic [1:0]
    {
        eRspRdLine = 2'd0,
        eRspWrLine = 2'd1
    } tRspKind;

    // ==============================
    // Requests
    // ==============================

    // Channel 0 read request
    typedef struct packed
    {
        logic                        rdValid;
        logic [`MPF_ADDR_WIDTH-1:0]  addr;
        tMdata                       mdata;
    } tReadReq;

    // Channel 1 write request
    typedef struct packed
    {
        logic                        wrValid;
        logic [`MPF_ADDR_WIDTH-1:0]  addr;
        tMdata                       mdata;
        logic [`MPF_DATA_WIDTH-1:0]  data;
    } tWriteReq;

    // ==============================
    // Responses
    // ==============================

    // Channel 0 carries read data and, when wrValid is set, write completions
    typedef struct packed
    {
        logic                        rdValid;
        logic                        wrValid;
        tRspKind                     kind;
        tMdata                       mdata;
        logic [`MPF_DATA_WIDTH-1:0]  data;
    } tRsp0;

    // Channel 1 carries write completions only
    typedef struct packed
    {
        logic                        wrValid;
        tMdata                       mdata;
    } tRsp1;

endpackage

/* hdl/rsp_scoreboard.sv */
`timescale 1ns/1ps

/*
 * Circular scoreboard that turns out-of-order arrivals into in-order release.
 * A slot is allocated at request time and its index travels with the request.
 * Data may land in any allocated slot; slots retire strictly from the head.
 * N_ENTRIES must be a power of two so the pointers wrap on their own.
 */

module rspScoreboard #(
    parameter int  N_ENTRIES      = 16,
    parameter int  MIN_FREE_SLOTS = 4,
    parameter type tData          = logic [63:0],
    parameter type tMeta          = logic [15:0]
)
(
    input  logic                         clk,
    input  logic                         rstN,

    // Allocation side, index is valid in the same cycle as enqEn
    input  logic                         enqEn,
    input  tMeta                         enqMeta,
    output logic [$clog2(N_ENTRIES)-1:0] enqIdx,
    output logic                         notFull,

    // Data arrival, any allocated slot in any order
    input  logic                         dataEn,
    input  logic [$clog2(N_ENTRIES)-1:0] dataIdx,
    input  tData                         dataIn,

    // In-order release from the head slot
    input  logic                         deqEn,
    output logic                         notEmpty,
    output tData                         first,
    output tMeta                         firstMeta
);

    localparam int             IDX_W       = $clog2(N_ENTRIES);
    localparam logic [IDX_W:0] TOTAL_SLOTS = (IDX_W+1)'(N_ENTRIES);
    localparam logic [IDX_W:0] RESERVE     = (IDX_W+1)'(MIN_FREE_SLOTS);

    // Oldest allocated slot and next slot to hand out
    logic [IDX_W-1:0]     headIdx;
    logic [IDX_W-1:0]     tailIdx;

    // Allocated slot count, one bit wider than an index so full is visible
    logic [IDX_W:0]       usedSlots;
    logic [IDX_W:0]       freeSlots;

    // Set when a slot's data has arrived, cleared when the slot retires
    logic [N_ENTRIES-1:0] filled;

    tMeta                 metaMem [N_ENTRIES];
    tData                 dataMem [N_ENTRIES];

    // Distance of an arriving tag from the head, used to spot stale tags
    logic [IDX_W-1:0]     dataOffset;

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            headIdx   <= '0;
            tailIdx   <= '0;
            usedSlots <= '0;
        end
        else
        begin
            if (enqEn)
            begin
                tailIdx <= tailIdx + 1'b1;
            end
            if (deqEn)
            begin
                headIdx <= headIdx + 1'b1;
            end
            usedSlots <= usedSlots + (IDX_W+1)'(enqEn) - (IDX_W+1)'(deqEn);
        end
    end

    // A slot is filled by its data and emptied only when the head retires it
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            filled <= '0;
        end
        else
        begin
            if (dataEn)
            begin
                filled[dataIdx] <= 1'b1;
            end
            if (deqEn)
            begin
                filled[headIdx] <= 1'b0;
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk)
    begin
        if (enqEn)
        begin
            metaMem[tailIdx] <= enqMeta;
        end
        if (dataEn)
        begin
            dataMem[dataIdx] <= dataIn;
        end
    end

    // ==============================
    // Outputs
    // ==============================

    assign enqIdx    = tailIdx;
    assign freeSlots = TOTAL_SLOTS - usedSlots;

    // The reserve lets requests already in flight land after notFull drops
    assign notFull   = (freeSlots >= RESERVE);

    // Release waits on the head slot alone, younger arrivals sit until then
    assign notEmpty  = filled[headIdx];
    assign first     = dataMem[headIdx];
    assign firstMeta = metaMem[headIdx];

    assign dataOffset = dataIdx - headIdx;

    // Retiring a slot whose data is not there would hand out stale payload
    aDeqWhenFilled: assert property (@(posedge clk) disable iff (!rstN)
        deqEn |-> notEmpty)
        else $error("rspScoreboard: dequeue with head slot not filled");

    // Arriving data must target a slot that was handed out and is still waiting
    aDataToOpenSlot: assert property (@(posedge clk) disable iff (!rstN)
        dataEn |-> (({1'b0, dataOffset} < usedSlots) && !filled[dataIdx]))
        else $error("rspScoreboard: data for unallocated or filled slot %0d", dataIdx);

    // Overrunning the ring would overwrite a live slot's metadata
    aEnqHasRoom: assert property (@(posedge clk) disable iff (!rstN)
        enqEn |-> (usedSlots < TOTAL_SLOTS))
        else $error("rspScoreboard: enqueue with no free slots");

endmodule

/* hdl/sort_read_rsp.sv */
`timescale 1ns/1ps

/*
 * Read-response sorting shim between user logic and an unordered platform port.
 * Outgoing reads carry a scoreboard tag in mdata; responses are restored
 * to request order with the user's mdata put back. Channel 1 passes through.
 */

`include "mpf_params.svh"

module sortReadRsp
    import mpfPkg::*;
(
    input  logic     clk,
    input  logic     rstN,

    // User side
    input  tReadReq  afuC0Tx,
    input  tWriteReq afuC1Tx,
    output tRsp0     afuC0Rx,
    output tRsp1     afuC1Rx,
    output logic     afuC0AlmFull,
    output logic     afuC1AlmFull,

    // Platform side
    output tReadReq  qlpC0Tx,
    output tWriteReq qlpC1Tx,
    input  tRsp0     qlpC0Rx,
    input  tRsp1     qlpC1Rx,
    input  logic     qlpC0AlmFull,
    input  logic     qlpC1AlmFull
);

    localparam int SB_IDX_W = $clog2(`MPF_SB_ENTRIES);

    logic [SB_IDX_W-1:0]        sbEnqIdx;
    logic                       sbNotFull;
    logic                       sbNotEmpty;
    logic [`MPF_DATA_WIDTH-1:0] sbFirst;
    tMdata                      sbFirstMeta;

    // Per-channel almost-full before any synchronization
    logic c0AlmFull;
    logic c1AlmFull;

    // High when a write completion owns channel 0 this cycle
    logic nonRdValid;

    // ==============================
    // Almost-full
    // ==============================

    // Scoreboard reserve covers the almost-full window, so no other buffering
    assign c0AlmFull = qlpC0AlmFull || !sbNotFull;
    assign c1AlmFull = qlpC1AlmFull;

    generate
        if (`MPF_SYNC_REQ_CHANNELS != 0)
        begin : gSyncChannels
            // Either channel filling stops both, which keeps load/store order
            assign afuC0AlmFull = c0AlmFull || c1AlmFull;
            assign afuC1AlmFull = c0AlmFull || c1AlmFull;
        end
        else
        begin : gIndependentChannels
            assign afuC0AlmFull = c0AlmFull;
            assign afuC1AlmFull = c1AlmFull;
        end
    endgenerate

    // ==============================
    // Channel 0, reads
    // ==============================

    rspScoreboard #(
        .N_ENTRIES      (`MPF_SB_ENTRIES),
        .MIN_FREE_SLOTS (`MPF_ALMOST_FULL_RESERVE),
        .tData          (logic [`MPF_DATA_WIDTH-1:0]),
        .tMeta          (tMdata)
    ) scoreboard (
        .clk       (clk),
        .rstN      (rstN),
        .enqEn     (afuC0Tx.rdValid),
        .enqMeta   (afuC0Tx.mdata),
        .enqIdx    (sbEnqIdx),
        .notFull   (sbNotFull),
        .dataEn    (qlpC0Rx.rdValid),
        .dataIdx   (qlpC0Rx.mdata[SB_IDX_W-1:0]),
        .dataIn    (qlpC0Rx.data),
        .deqEn     (afuC0Rx.rdValid),
        .notEmpty  (sbNotEmpty),
        .first     (sbFirst),
        .firstMeta (sbFirstMeta)
    );

    // The platform sees the slot tag, the user's mdata waits in the scoreboard
    always_comb
    begin
        qlpC0Tx       = afuC0Tx;
        qlpC0Tx.mdata = tMdata'(sbEnqIdx);
    end

    // Write completions are unbuffered, so they win the channel over a release
    always_comb
    begin
        nonRdValid      = qlpC0Rx.wrValid;
        afuC0Rx         = qlpC0Rx;
        afuC0Rx.rdValid = sbNotEmpty && !nonRdValid;

        // Rebuild the read header from the saved mdata
        if (afuC0Rx.rdValid)
        begin
            afuC0Rx.kind  = eRspRdLine;
            afuC0Rx.mdata = sbFirstMeta;
            afuC0Rx.data  = sbFirst;
        end
    end

    // A write completion goes out alone, with no read release beside it
    aWriteBlocksRelease: assert property (@(posedge clk) disable iff (!rstN)
        qlpC0Rx.wrValid |-> (afuC0Rx.wrValid && !afuC0Rx.rdValid))
        else $error("sortReadRsp: read release overlaps a write response");

    // A read blocked by a write is still waiting at the head on the next cycle
    aBlockedReadHeld: assert property (@(posedge clk) disable iff (!rstN)
        (sbNotEmpty && qlpC0Rx.wrValid) |=> sbNotEmpty)
        else $error("sortReadRsp: blocked read response was lost");

    // ==============================
    // Channel 1, writes
    // ==============================

    assign qlpC1Tx = afuC1Tx;
    assign afuC1Rx = qlpC1Rx;

endmodule

/* hdl/mpf_sort_top.sv */
`timescale 1ns/1ps

/*
 * Top level of the sorting shim.
 * Exposes the user and platform channel ports; all work is in sortReadRsp.
 */

module mpfSortTop
    import mpfPkg::*;
(
    input  logic     clk,
    input  logic     rstN,

    // User side, sees read responses in issue order
    input  tReadReq  afuC0Tx,
    input  tWriteReq afuC1Tx,
    output tRsp0     afuC0Rx,
    output tRsp1     afuC1Rx,
    output logic     afuC0AlmFull,
    output logic     afuC1AlmFull,

    // Platform side, may answer reads in any order
    output tReadReq  qlpC0Tx,
    output tWriteReq qlpC1Tx,
    input  tRsp0     qlpC0Rx,
    input  tRsp1     qlpC1Rx,
    input  logic     qlpC0AlmFull,
    input  logic     qlpC1AlmFull
);

    sortReadRsp sorter (
        .clk          (clk),
        .rstN         (rstN),
        .afuC0Tx      (afuC0Tx),
        .afuC1Tx      (afuC1Tx),
        .afuC0Rx      (afuC0Rx),
        .afuC1Rx      (afuC1Rx),
        .afuC0AlmFull (afuC0AlmFull),
        .afuC1AlmFull (afuC1AlmFull),
        .qlpC0Tx      (qlpC0Tx),
        .qlpC1Tx      (qlpC1Tx),
        .qlpC0Rx      (qlpC0Rx),
        .qlpC1Rx      (qlpC1Rx),
        .qlpC0AlmFull (qlpC0AlmFull),
        .qlpC1AlmFull (qlpC1AlmFull)
    );

endmodule

/* tests/platform_model.sv */
`timescale 1ns/1ps

/*
 * Platform memory model for the sorting shim testbench.
 * Holds tagged read requests and answers them in random order with data
 * made from the address. Writes come back as completions on channel 0.
 */

module platformModel
    import mpfPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    // Holds all read responses back while high
    input  logic     stall,
    input  tReadReq  c0Tx,
    input  tWriteReq c1Tx,
    output tRsp0     c0Rx,
    output tRsp1     c1Rx
);

    // Reads waiting for an answer, in arrival order
    tReadReq  pending [$];

    // Write request seen on the last edge, answered on this one
    tWriteReq wrHold;

    // Idle cycles left before the next read answer
    int       gap;

    // One seed for the whole run
    initial
    begin
        void'($urandom(89));
    end

    // Channel 1 shows each held write one cycle before its channel 0 completion
    assign c1Rx.wrValid = wrHold.wrValid;
    assign c1Rx.mdata   = wrHold.mdata;

    always @(posedge clk or negedge rstN)
    begin
        tRsp0 rsp;
        int   pick;
        if (!rstN)
        begin
            c0Rx   <= '0;
            wrHold <= '0;
            gap    <= 0;
            pending.delete();
        end
        else
        begin
            rsp = '0;
            if (c0Tx.rdValid)
            begin
                pending.push_back(c0Tx);
            end
            wrHold <= c1Tx;

            // A write completion takes the channel, the read waits a cycle
            if (wrHold.wrValid)
            begin
                rsp.wrValid = 1'b1;
                rsp.kind    = eRspWrLine;
                rsp.mdata   = wrHold.mdata;
            end
            else if (gap > 0)
            begin
                gap <= gap - 1;
            end
            else if (!stall && (pending.size() > 0))
            begin
                // Any waiting read may go first, which is what the shim must undo
                pick        = $urandom % pending.size();
                rsp.rdValid = 1'b1;
                rsp.kind    = eRspRdLine;
                rsp.mdata   = pending[pick].mdata;
                rsp.data    = 64'(pending[pick].addr) ^ 64'hA5A5_0000_5A5A_FFFF;
                pending.delete(pick);
                gap <= $urandom % 4;
            end
            c0Rx <= rsp;
        end
    end

endmodule

/* tests/tb_mpf_sort.sv */
`timescale 1ns/1ps

/*
 * Testbench for the read-response sorting shim.
 * Applies a table of read and write bursts, checks order, headers and data
 * of every response, channel 1 passthrough and the almost-full flags.
 */

`include "mpf_params.svh"

module tbMpfSort
    import mpfPkg::*;
();

    // One table row is a burst of count requests with rising addr and mdata
    typedef struct packed
    {
        tRspKind                    kind;
        logic [`MPF_ADDR_WIDTH-1:0] addr;
        tMdata                      mdata;
        int                         count;
    } stimRow;

    // What a read response must carry, in issue order
    typedef struct packed
    {
        tMdata                      mdata;
        logic [`MPF_DATA_WIDTH-1:0] data;
    } expRsp;

    // Rows 0 ordered return, 1 to 4 write priority, 5 almost-full
    localparam stimRow STIM [6] = '{
        '{eRspRdLine, 32'h0000_1000, 16'h0100, 8},
        '{eRspRdLine, 32'h0000_2000, 16'h0200, 3},
        '{eRspWrLine, 32'h0000_3000, 16'h0300, 2},
        '{eRspRdLine, 32'h0000_2100, 16'h0210, 3},
        '{eRspWrLine, 32'h0000_3100, 16'h0310, 1},
        '{eRspRdLine, 32'h0000_4000, 16'h0400,
          `MPF_SB_ENTRIES - `MPF_ALMOST_FULL_RESERVE + 1}
    };

    logic     clk = 1'b0;
    logic     rstN;
    logic     stallPlatform;
    tReadReq  afuC0Tx;
    tWriteReq afuC1Tx;
    tRsp0     afuC0Rx;
    tRsp1     afuC1Rx;
    logic     afuC0AlmFull;
    logic     afuC1AlmFull;
    tReadReq  qlpC0Tx;
    tWriteReq qlpC1Tx;
    tRsp0     qlpC0Rx;
    tRsp1     qlpC1Rx;
    logic     qlpC0AlmFull;
    logic     qlpC1AlmFull;

    expRsp    expRd [$];
    tMdata    expWr [$];
    int       errorCount  = 0;
    int       checkCount  = 0;
    int       testCount   = 0;
    int       issuedCount = 0;
    int       rspCount    = 0;
    int       passSamples = 0;
    int       passErrors  = 0;

    always #10 clk = ~clk;

    mpfSortTop uut (
        .clk          (clk),
        .rstN         (rstN),
        .afuC0Tx      (afuC0Tx),
        .afuC1Tx      (afuC1Tx),
        .afuC0Rx      (afuC0Rx),
        .afuC1Rx      (afuC1Rx),
        .afuC0AlmFull (afuC0AlmFull),
        .afuC1AlmFull (afuC1AlmFull),
        .qlpC0Tx      (qlpC0Tx),
        .qlpC1Tx      (qlpC1Tx),
        .qlpC0Rx      (qlpC0Rx),
        .qlpC1Rx      (qlpC1Rx),
        .qlpC0AlmFull (qlpC0AlmFull),
        .qlpC1AlmFull (qlpC1AlmFull)
    );

    platformModel platform (
        .clk   (clk),
        .rstN  (rstN),
        .stall (stallPlatform),
        .c0Tx  (qlpC0Tx),
        .c1Tx  (qlpC1Tx),
        .c0Rx  (qlpC0Rx),
        .c1Rx  (qlpC1Rx)
    );

    // ==============================
    // Helpers
    // ==============================

    // The platform answers a read with its address folded into a fixed pattern
    function automatic logic [`MPF_DATA_WIDTH-1:0] expectedLineData(
        input logic [`MPF_ADDR_WIDTH-1:0] addr);
        return 64'(addr) ^ 64'hA5A5_0000_5A5A_FFFF;
    endfunction

    function automatic int totalRequests();
        int total;
        total = 0;
        foreach (STIM[r])
        begin
            total += STIM[r].count;
        end
        return total;
    endfunction

    task automatic reportMismatch(input string sigName, input logic [127:0] expVal,
                                  input logic [127:0] gotVal);
        $display("mismatch at %0t ns: %s expected %0h got %0h", $time, sigName, expVal, gotVal);
        errorCount++;
    endtask

    task automatic checkValue(input string sigName, input logic [127:0] expVal,
                              input logic [127:0] gotVal);
        checkCount++;
        if (expVal !== gotVal)
        begin
            reportMismatch(sigName, expVal, gotVal);
        end
    endtask

    // Called at 2 ns after an edge, returns at the same point of a later cycle
    task automatic issueRow(input stimRow row, input bit honorAlmFull);
        expRsp e;
        for (int i = 0; i < row.count; i++)
        begin
            while (honorAlmFull && (afuC0AlmFull || afuC1AlmFull))
            begin
                @(posedge clk);
                #2;
            end
            if (row.kind == eRspRdLine)
            begin
                afuC0Tx.rdValid = 1'b1;
                afuC0Tx.addr    = row.addr + 32'(i);
                afuC0Tx.mdata   = row.mdata + tMdata'(i);
                e.mdata         = afuC0Tx.mdata;
                e.data          = expectedLineData(afuC0Tx.addr);
                expRd.push_back(e);
            end
            else
            begin
                afuC1Tx.wrValid = 1'b1;
                afuC1Tx.addr    = row.addr + 32'(i);
                afuC1Tx.mdata   = row.mdata + tMdata'(i);
                afuC1Tx.data    = 64'(afuC1Tx.addr);
                expWr.push_back(afuC1Tx.mdata);
            end
            issuedCount++;
            @(posedge clk);
            #2;
            afuC0Tx = '0;
            afuC1Tx = '0;
        end
    endtask

    // Waits until every outstanding response has been seen by the monitor
    task automatic waitDrain();
        while ((expRd.size() != 0) || (expWr.size() != 0))
        begin
            @(posedge clk);
        end
        #2;
    endtask

    task automatic reportTest(input string name, input int errorsBefore,
                              input int issuedBefore, input int rspBefore);
        int issued;
        int received;
        issued   = issuedCount - issuedBefore;
        received = rspCount - rspBefore;
        checkCount++;
        if (received != issued)
        begin
            $display("error at %0t ns: %s issued %0d requests but got %0d responses",
                     $time, name, issued, received);
            errorCount++;
        end
        testCount++;
        $display("test %s: %0d requests, %0d errors", name, issued, errorCount - errorsBefore);
    endtask

    task automatic runTest(input string name, input int firstRow, input int lastRow);
        int errorsBefore;
        int issuedBefore;
        int rspBefore;
        errorsBefore = errorCount;
        issuedBefore = issuedCount;
        rspBefore    = rspCount;
        for (int r = firstRow; r <= lastRow; r++)
        begin
            issueRow(STIM[r], 1'b1);
        end
        waitDrain();
        reportTest(name, errorsBefore, issuedBefore, rspBefore);
    endtask

    task automatic runAlmostFullTest();
        int errorsBefore;
        int issuedBefore;
        int rspBefore;
        errorsBefore = errorCount;
        issuedBefore = issuedCount;
        rspBefore    = rspCount;

        // Fill past the reserve while nothing comes back
        stallPlatform = 1'b1;
        issueRow(STIM[5], 1'b0);
        checkValue("afuC0AlmFull", 128'(1'b1), 128'(afuC0AlmFull));
        checkValue("afuC1AlmFull", 128'(1'b1), 128'(afuC1AlmFull));

        stallPlatform = 1'b0;
        waitDrain();
        checkValue("afuC0AlmFull", 128'(1'b0), 128'(afuC0AlmFull));
        checkValue("afuC1AlmFull", 128'(1'b0), 128'(afuC1AlmFull));

        // With the channels merged, channel 1 filling also stops reads
        qlpC1AlmFull = 1'b1;
        @(negedge clk);
        checkValue("afuC0AlmFull", 128'(1'b1), 128'(afuC0AlmFull));
        @(posedge clk);
        #2;
        qlpC1AlmFull = 1'b0;
        reportTest("almost-full", errorsBefore, issuedBefore, rspBefore);
    endtask

    // ==============================
    // Response monitor
    // ==============================

    // Sampled mid-cycle, where every output has settled
    always @(negedge clk)
    begin
        expRsp e;
        if (rstN)
        begin
            if (afuC0Rx.wrValid)
            begin
                rspCount++;
                checkValue("afuC0Rx.kind", 128'(eRspWrLine), 128'(afuC0Rx.kind));
                if (expWr.size() == 0)
                begin
                    $display("error at %0t ns: write response with no write outstanding", $time);
                    errorCount++;
                end
                else
                begin
                    checkValue("afuC0Rx.mdata", 128'(expWr.pop_front()), 128'(afuC0Rx.mdata));
                end
            end
            if (afuC0Rx.rdValid)
            begin
                rspCount++;
                if (expRd.size() == 0)
                begin
                    $display("error at %0t ns: read response with no read outstanding", $time);
                    errorCount++;
                end
                else
                begin
                    e = expRd.pop_front();
                    checkValue("afuC0Rx.kind", 128'(eRspRdLine), 128'(afuC0Rx.kind));
                    checkValue("afuC0Rx.mdata", 128'(e.mdata), 128'(afuC0Rx.mdata));
                    checkValue("afuC0Rx.data", 128'(e.data), 128'(afuC0Rx.data));
                end
            end

            // Channel 1 goes through untouched in both directions in the same cycle
            passSamples++;
            if (qlpC1Tx !== afuC1Tx)
            begin
                reportMismatch("qlpC1Tx", 128'(afuC1Tx), 128'(qlpC1Tx));
                passErrors++;
            end
            if (afuC1Rx !== qlpC1Rx)
            begin
                reportMismatch("afuC1Rx", 128'(qlpC1Rx), 128'(afuC1Rx));
                passErrors++;
            end
        end
    end

    // ==============================
    // Watchdog and main sequence
    // ==============================

    initial
    begin
        int limit;
        limit = totalRequests() * 20 + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: responses still outstanding after %0d cycles", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        rstN          = 1'b0;
        stallPlatform = 1'b0;
        afuC0Tx       = '0;
        afuC1Tx       = '0;
        qlpC0AlmFull  = 1'b0;
        qlpC1AlmFull  = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rstN = 1'b1;

        // Nothing leaves an empty scoreboard, and the flags are clear
        checkValue("afuC0Rx.rdValid", 128'(1'b0), 128'(afuC0Rx.rdValid));
        checkValue("afuC0AlmFull", 128'(1'b0), 128'(afuC0AlmFull));
        checkValue("afuC1AlmFull", 128'(1'b0), 128'(afuC1AlmFull));

        runTest("ordered read return", 0, 0);
        runTest("write priority", 1, 4);
        runAlmostFullTest();
        testCount++;
        $display("test channel 1 passthrough: %0d samples, %0d errors", passSamples, passErrors);

        $display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
hdl/mpf_pkg.sv
hdl/rsp_scoreboard.sv
hdl/sort_read_rsp.sv
hdl/mpf_sort_top.sv
tests/platform_model.sv
tests/tb_mpf_sort.sv

/* run.sh */
#!/bin/sh
# Build the sorting shim testbench with Verilator and run it.
# Exits non-zero unless the simulation reports success.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sim.f --top-module tbMpfSort -o simTbMpfSort
status=$?
if [ "$status" -ne 0 ]; then
    echo "run.sh: Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/simTbMpfSort 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "PASS: all tests"; then
    exit 0
fi
echo "run.sh: simulation did not report success"
exit 1
